// ==== hdl/gpio_settings.svh ====
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// APB address width, byte address
`define GPIO_ADDR_WIDTH 12

// APB data width, multiple of 8
`define GPIO_DATA_WIDTH 32

// One strobe bit per data byte
`define GPIO_STRB_WIDTH (`GPIO_DATA_WIDTH/8)

// Number of pins, 1 to 32
`define GPIO_WIDTH 16

// Flops in the input synchronizer
`define GPIO_SYNC_STAGES 2

`endif

// ==== hdl/gpio_pkg.sv ====
`default_nettype none
`include "gpio_settings.svh"

package gpio_pkg;

    typedef struct packed {
        logic [`GPIO_ADDR_WIDTH-1:0] paddr;
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`GPIO_DATA_WIDTH-1:0] pwdata;
        logic [`GPIO_STRB_WIDTH-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic [`GPIO_DATA_WIDTH-1:0] prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

    // Power/debug freeze handshake, levels only
    typedef struct packed {
        logic req;
        logic ack;
    } pause_t;

    typedef struct packed {
        logic [`GPIO_WIDTH-1:0] out;   // ODR
        logic [`GPIO_WIDTH-1:0] mode;  // 1 = output
        logic [`GPIO_WIDTH-1:0] otype; // 1 = open-drain
    } pin_cfg_t;

    typedef struct packed {
        logic [`GPIO_WIDTH-1:0] alt1;
        logic [`GPIO_WIDTH-1:0] alt2;
        logic [`GPIO_WIDTH-1:0] alt3;
    } alt_out_t;

    // fsr1 in the upper word so the struct reads as one 2-bit-per-pin vector
    typedef struct packed {
        logic [`GPIO_DATA_WIDTH-1:0] fsr1;
        logic [`GPIO_DATA_WIDTH-1:0] fsr0;
    } fsr_t;

    typedef enum logic [1:0] {
        FUNC_GPIO = 2'd0,
        FUNC_ALT1 = 2'd1,
        FUNC_ALT2 = 2'd2,
        FUNC_ALT3 = 2'd3
    } func_sel_t;

    // Word index, paddr without the byte offset
    typedef enum logic [9:0] {
        REG_IDR    = 10'd0,
        REG_ODR    = 10'd1,
        REG_MODER  = 10'd2,
        REG_OTYPER = 10'd3,
        REG_FSR0   = 10'd4,
        REG_FSR1   = 10'd5,
        REG_IER    = 10'd6
    } reg_index_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESP,
        ST_PAUSED
    } slave_state_t;

endpackage

`default_nettype wire

// ==== hdl/gpio_regs.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gpio_settings.svh"

module gpio_regs (
    input  logic                   seq,
    input  logic                   reset,
    input  gpio_pkg::apb_req_t     apb_req,
    output gpio_pkg::apb_rsp_t     apb_rsp,
    input  logic                   pause_req,
    output logic                   pause_ack,
    output logic                   irq,
    input  logic [`GPIO_WIDTH-1:0] pin_sync,
    output gpio_pkg::pin_cfg_t     pin_cfg,
    output gpio_pkg::fsr_t         fsr
);

    localparam int unsigned OFFSET_BITS = $clog2(`GPIO_STRB_WIDTH);

    gpio_pkg::slave_state_t      state;
    gpio_pkg::reg_index_t        index;
    gpio_pkg::apb_rsp_t          rsp_q;
    gpio_pkg::pin_cfg_t          cfg_q;
    gpio_pkg::fsr_t              fsr_q;
    logic [`GPIO_WIDTH-1:0]      ier;
    logic [`GPIO_DATA_WIDTH-1:0] wmask;
    logic [`GPIO_DATA_WIDTH-1:0] rd_data;
    logic                        rd_err;
    logic                        accept;
    logic                        wr_en;

    function automatic logic [`GPIO_DATA_WIDTH-1:0] merge_word(
        input logic [`GPIO_DATA_WIDTH-1:0] old_word,
        input logic [`GPIO_DATA_WIDTH-1:0] new_word,
        input logic [`GPIO_DATA_WIDTH-1:0] mask
    );
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    // Pin-wide registers drop the bits above GPIO_WIDTH
    function automatic logic [`GPIO_WIDTH-1:0] merge_pin(
        input logic [`GPIO_WIDTH-1:0]      old_bits,
        input logic [`GPIO_DATA_WIDTH-1:0] new_word,
        input logic [`GPIO_DATA_WIDTH-1:0] mask
    );
        return `GPIO_WIDTH'(merge_word(`GPIO_DATA_WIDTH'(old_bits), new_word, mask));
    endfunction

    assign index = gpio_pkg::reg_index_t'(apb_req.paddr[`GPIO_ADDR_WIDTH-1:OFFSET_BITS]);

    // Byte strobes to bit mask
    always_comb begin
        for (int b = 0; b < `GPIO_STRB_WIDTH; b++) begin
            wmask[b*8 +: 8] = {8{apb_req.pstrb[b]}};
        end
    end

    // Read mux and refusal check
    always_comb begin
        rd_data = '0;
        rd_err  = 1'b0;
        case (index)
            gpio_pkg::REG_IDR: begin
                rd_data = `GPIO_DATA_WIDTH'(pin_sync);
                rd_err  = apb_req.pwrite; // read only
            end
            gpio_pkg::REG_ODR:    rd_data = `GPIO_DATA_WIDTH'(cfg_q.out);
            gpio_pkg::REG_MODER:  rd_data = `GPIO_DATA_WIDTH'(cfg_q.mode);
            gpio_pkg::REG_OTYPER: rd_data = `GPIO_DATA_WIDTH'(cfg_q.otype);
            gpio_pkg::REG_FSR0:   rd_data = fsr_q.fsr0;
            gpio_pkg::REG_FSR1:   rd_data = fsr_q.fsr1;
            gpio_pkg::REG_IER:    rd_data = `GPIO_DATA_WIDTH'(ier);
            default:              rd_err  = 1'b1; // unmapped
        endcase
    end

    // Setup phase already counts, so pready comes up with penable
    assign accept = (state == gpio_pkg::ST_IDLE) && apb_req.psel && !pause_req;
    assign wr_en  = accept && apb_req.pwrite && !rd_err;

    always_ff @(posedge seq) begin
        if (reset) begin
            cfg_q <= '0;
            fsr_q <= '0;
            ier   <= '0;
        end else if (wr_en) begin
            case (index)
                gpio_pkg::REG_ODR:    cfg_q.out   <= merge_pin(cfg_q.out, apb_req.pwdata, wmask);
                gpio_pkg::REG_MODER:  cfg_q.mode  <= merge_pin(cfg_q.mode, apb_req.pwdata, wmask);
                gpio_pkg::REG_OTYPER: cfg_q.otype <= merge_pin(cfg_q.otype, apb_req.pwdata, wmask);
                gpio_pkg::REG_FSR0: begin
                    fsr_q.fsr0 <= merge_word(fsr_q.fsr0, apb_req.pwdata, wmask);
                end
                gpio_pkg::REG_FSR1: begin
                    fsr_q.fsr1 <= merge_word(fsr_q.fsr1, apb_req.pwdata, wmask);
                end
                gpio_pkg::REG_IER:    ier <= merge_pin(ier, apb_req.pwdata, wmask);
                default: ;            // IDR and unmapped already refused
            endcase
        end
    end

    // Response and freeze FSM
    always_ff @(posedge seq) begin
        if (reset) begin
            state <= gpio_pkg::ST_IDLE;
            rsp_q <= '0;
        end else begin
            case (state)
                gpio_pkg::ST_IDLE: begin
                    if (pause_req) begin
                        // Tie the bus off, every access ends in an error
                        state         <= gpio_pkg::ST_PAUSED;
                        rsp_q.prdata  <= '0;
                        rsp_q.pready  <= 1'b1;
                        rsp_q.pslverr <= 1'b1;
                    end else if (accept) begin
                        state         <= gpio_pkg::ST_RESP;
                        rsp_q.prdata  <= apb_req.pwrite ? '0 : rd_data;
                        rsp_q.pready  <= 1'b1;
                        rsp_q.pslverr <= rd_err;
                    end
                end
                gpio_pkg::ST_RESP: begin
                    if (apb_req.psel && apb_req.penable) begin // pready is high here
                        state <= gpio_pkg::ST_IDLE;
                        rsp_q <= '0;
                    end
                end
                gpio_pkg::ST_PAUSED: begin
                    if (!pause_req) begin
                        state <= gpio_pkg::ST_IDLE;
                        rsp_q <= '0;
                    end
                end
                default: begin
                    state <= gpio_pkg::ST_IDLE;
                    rsp_q <= '0;
                end
            endcase
        end
    end

    assign pause_ack = (state == gpio_pkg::ST_PAUSED);
    assign apb_rsp   = rsp_q;
    assign pin_cfg   = cfg_q;
    assign fsr       = fsr_q;

    // Level interrupt, masked while frozen
    assign irq = (|(ier & pin_sync)) && !pause_ack;

endmodule

`default_nettype wire

// ==== hdl/gpio_func_mux.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gpio_settings.svh"

module gpio_func_mux (
    input  gpio_pkg::pin_cfg_t     pin_cfg,
    input  gpio_pkg::fsr_t         fsr,
    input  gpio_pkg::alt_out_t     alt_out,
    output logic [`GPIO_WIDTH-1:0] pin_value
);

    // FSR1:FSR0 as one vector, two bits per pin
    logic [2*`GPIO_DATA_WIDTH-1:0] fsr_bits;

    assign fsr_bits = fsr;

    for (genvar i = 0; i < `GPIO_WIDTH; i++) begin : g_pin
        gpio_pkg::func_sel_t code;

        assign code = gpio_pkg::func_sel_t'(fsr_bits[2*i +: 2]);

        always_comb begin
            case (code)
                gpio_pkg::FUNC_GPIO: pin_value[i] = pin_cfg.out[i];
                gpio_pkg::FUNC_ALT1: pin_value[i] = alt_out.alt1[i];
                gpio_pkg::FUNC_ALT2: pin_value[i] = alt_out.alt2[i];
                gpio_pkg::FUNC_ALT3: pin_value[i] = alt_out.alt3[i];
                default:             pin_value[i] = pin_cfg.out[i];
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gpio_pad.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gpio_settings.svh"

module gpio_pad (
    input  logic                   seq,
    input  logic                   reset,
    input  logic [`GPIO_WIDTH-1:0] pin_in,
    input  logic [`GPIO_WIDTH-1:0] pin_value,
    input  logic [`GPIO_WIDTH-1:0] mode,
    input  logic [`GPIO_WIDTH-1:0] otype,
    output logic [`GPIO_WIDTH-1:0] pin_sync,
    output logic [`GPIO_WIDTH-1:0] pin_out,
    output logic [`GPIO_WIDTH-1:0] pin_oe
);

    // Stage 0 samples the pins, last stage feeds IDR
    logic [`GPIO_SYNC_STAGES-1:0][`GPIO_WIDTH-1:0] sync_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= pin_in;
            for (int s = 1; s < `GPIO_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign pin_sync = sync_q[`GPIO_SYNC_STAGES-1];

    // Value always presented, the enable decides whether it is driven
    assign pin_out = pin_value;

    // Push-pull drives both levels
    // Open-drain drives only a low, a high releases the pin
    assign pin_oe = mode & (~otype | ~pin_value);

endmodule

`default_nettype wire

// ==== hdl/gpio_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gpio_settings.svh"

module gpio_top (
    input  logic                   seq,
    input  logic                   reset,
    input  gpio_pkg::apb_req_t     apb_req,
    output gpio_pkg::apb_rsp_t     apb_rsp,
    input  logic                   pause_req,
    output logic                   pause_ack,
    output logic                   irq,
    input  logic [`GPIO_WIDTH-1:0] pin_in,
    input  gpio_pkg::alt_out_t     alt_out,
    output logic [`GPIO_WIDTH-1:0] pin_out,
    output logic [`GPIO_WIDTH-1:0] pin_oe
);

    gpio_pkg::pin_cfg_t     pin_cfg;
    gpio_pkg::fsr_t         fsr;
    logic [`GPIO_WIDTH-1:0] pin_sync;  // synchronized inputs, also IDR
    logic [`GPIO_WIDTH-1:0] pin_value; // selected output source

    gpio_regs u_regs (
        .seq       (seq),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .pin_sync  (pin_sync),
        .pin_cfg   (pin_cfg),
        .fsr       (fsr)
    );

    gpio_func_mux u_func_mux (
        .pin_cfg   (pin_cfg),
        .fsr       (fsr),
        .alt_out   (alt_out),
        .pin_value (pin_value)
    );

    gpio_pad u_pad (
        .seq       (seq),
        .reset     (reset),
        .pin_in    (pin_in),
        .pin_value (pin_value),
        .mode      (pin_cfg.mode),
        .otype     (pin_cfg.otype),
        .pin_sync  (pin_sync),
        .pin_out   (pin_out),
        .pin_oe    (pin_oe)
    );

endmodule

`default_nettype wire

// ==== tests/gpio_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module gpio_props (
    input logic               seq,
    input logic               reset,
    input gpio_pkg::apb_req_t apb_req,
    input gpio_pkg::apb_rsp_t apb_rsp,
    input logic               pause_req,
    input logic               pause_ack,
    input logic               irq
);

    gpio_pkg::pause_t pause;

    assign pause = {pause_req, pause_ack};

    // A response needs a selected access or a frozen slave
    ready_cause: assert property (@(posedge seq) disable iff (reset)
        $rose(apb_rsp.pready) |-> $past(apb_req.psel) || pause.ack)
        else $error("pready rose without psel or pause_ack");

    ack_after_req: assert property (@(posedge seq) disable iff (reset)
        $rose(pause.ack) |-> $past(pause.req))
        else $error("pause_ack rose without pause_req");

    err_with_ready: assert property (@(posedge seq) disable iff (reset)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else $error("pslverr high without pready");

    // First edge out of reset
    reset_values: assert property (@(posedge seq)
        $fell(reset) |-> !apb_rsp.pready && !pause.ack)
        else $error("pready or pause_ack high after reset");

    irq_masked: assert property (@(posedge seq) disable iff (reset)
        pause.ack |-> !irq)
        else $error("irq high while paused");

endmodule

bind gpio_regs gpio_props u_props (
    .seq       (seq),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .pause_req (pause_req),
    .pause_ack (pause_ack),
    .irq       (irq)
);

`default_nettype wire

// ==== tests/gpio_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "gpio_settings.svh"

module gpio_tb;

    localparam int NUM_TESTS    = 6;
    localparam int TEST_TIME_NS = 2000; // budget per test
    localparam int READY_LIMIT  = 16;   // cycles to wait for pready or pause_ack
    localparam logic [31:0] PIN_MASK = 32'((64'd1 << `GPIO_WIDTH) - 64'd1);

    logic                   seq;
    logic                   reset;
    gpio_pkg::apb_req_t     apb_req;
    gpio_pkg::apb_rsp_t     apb_rsp;
    logic                   pause_req;
    logic                   pause_ack;
    logic                   irq;
    logic [`GPIO_WIDTH-1:0] pin_in;
    logic [`GPIO_WIDTH-1:0] pin_out;
    logic [`GPIO_WIDTH-1:0] pin_oe;
    gpio_pkg::alt_out_t     alt_out;

    integer seed;
    int     errors;
    int     checks;

    gpio_top uut (
        .seq       (seq),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq),
        .pin_in    (pin_in),
        .alt_out   (alt_out),
        .pin_out   (pin_out),
        .pin_oe    (pin_oe)
    );

    always #5 seq = ~seq;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // Old word with the strobed bytes replaced
    function automatic logic [31:0] strobe_merge(input logic [31:0] old_val,
                                                  input logic [31:0] new_val,
                                                  input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] reg_mask(input logic [9:0] idx);
        if (idx == gpio_pkg::REG_FSR0 || idx == gpio_pkg::REG_FSR1) return 32'hffff_ffff;
        return PIN_MASK; // pin-wide register
    endfunction

    // Setup cycle, access cycle, then hold until pready
    task automatic apb_access(input logic write, input logic [9:0] idx, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        rdata  = '0;
        err    = 1'b1;
        @(posedge seq);
        apb_req.paddr   <= {idx, 2'b00};
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        apb_req.pstrb   <= write ? strb : 4'h0;
        @(posedge seq);
        apb_req.penable <= 1'b1;
        @(negedge seq);
        while (!apb_rsp.pready && waited < READY_LIMIT) begin
            @(negedge seq);
            waited++;
        end
        if (!apb_rsp.pready) begin
            errors++;
            $display("APB access to index %0d never got pready at %0t ns", idx, $time);
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
        end
        @(posedge seq);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [9:0] idx, input logic [31:0] data,
                             input logic [3:0] strb, output logic err);
        logic [31:0] unused_rdata;
        apb_access(1'b1, idx, data, strb, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [9:0] idx, output logic [31:0] data, output logic err);
        apb_access(1'b0, idx, 32'd0, 4'h0, data, err);
    endtask

    // Full-word write that must succeed
    task automatic write_word(input logic [9:0] idx, input logic [31:0] data);
        logic err;
        apb_write(idx, data, 4'hf, err);
        check(32'(err), 32'd0, $sformatf("pslverr on write to index %0d", idx));
    endtask

    task automatic wait_pause_ack(input logic level);
        int waited;
        waited = 0;
        @(negedge seq);
        while (pause_ack !== level && waited < READY_LIMIT) begin
            @(negedge seq);
            waited++;
        end
        if (pause_ack !== level) begin
            errors++;
            $display("pause_ack did not go to %0d at %0t ns", level, $time);
        end
    endtask

    task automatic test_reset_and_strobes();
        logic [31:0] shadow [0:6];
        logic [31:0] data;
        logic [31:0] got;
        logic [3:0]  strb;
        logic        err;
        $display("Test 1: reset values, readback and strobes");
        for (int r = 0; r < 7; r++) begin
            apb_read(10'(r), got, err);
            check(32'(err), 32'd0, $sformatf("pslverr on reset read of index %0d", r));
            check(got, 32'd0, $sformatf("reset value of index %0d", r));
            shadow[r] = 32'd0;
        end
        @(negedge seq);
        check(32'(pin_oe), 32'd0, "pin_oe after reset");
        for (int round = 0; round < 3; round++) begin
            for (int r = 1; r < 7; r++) begin
                data      = $random(seed);
                strb      = 4'($random(seed));
                shadow[r] = strobe_merge(shadow[r], data, strb) & reg_mask(10'(r));
                apb_write(10'(r), data, strb, err);
                check(32'(err), 32'd0, $sformatf("pslverr on strobed write to index %0d", r));
                apb_read(10'(r), got, err);
                check(got, shadow[r], $sformatf("readback of index %0d, pstrb %h", r, strb));
            end
        end
    endtask

    task automatic test_error_responses();
        logic [`GPIO_WIDTH-1:0] pattern;
        logic [31:0]            got;
        logic [31:0]            r;
        logic [9:0]             idx;
        logic                   err;
        $display("Test 2: error responses");
        pattern = `GPIO_WIDTH'($random(seed));
        @(posedge seq);
        pin_in <= pattern;
        repeat (`GPIO_SYNC_STAGES + 1) @(posedge seq);
        apb_read(gpio_pkg::REG_IDR, got, err);
        check(got, 32'(pattern), "IDR before refused write");
        apb_write(gpio_pkg::REG_IDR, ~32'(pattern), 4'hf, err);
        check(32'(err), 32'd1, "write to IDR not refused");
        apb_read(gpio_pkg::REG_IDR, got, err);
        check(got, 32'(pattern), "IDR changed by refused write");
        for (int k = 0; k < 4; k++) begin
            r   = $random(seed);
            idx = (k == 0) ? 10'd7 : 10'd7 + 10'(r[8:0]);
            apb_read(idx, got, err);
            check(32'(err), 32'd1, $sformatf("read of unmapped index %0d not refused", idx));
            check(got, 32'd0, $sformatf("prdata of unmapped index %0d", idx));
            apb_write(idx, $random(seed), 4'hf, err);
            check(32'(err), 32'd1, $sformatf("write to unmapped index %0d not refused", idx));
        end
    endtask

    task automatic test_input_irq();
        logic [`GPIO_WIDTH-1:0] pattern;
        logic [`GPIO_WIDTH-1:0] ier;
        logic [31:0]            got;
        logic                   err;
        $display("Test 3: input path and interrupt");
        pattern = `GPIO_WIDTH'($random(seed));
        @(posedge seq);
        pin_in <= pattern;
        repeat (`GPIO_SYNC_STAGES + 2) @(posedge seq);
        apb_read(gpio_pkg::REG_IDR, got, err);
        check(got, 32'(pattern), "IDR against pin_in");
        for (int k = 0; k < 3; k++) begin
            case (k)
                0:       ier = `GPIO_WIDTH'($random(seed));
                1:       ier = ~pattern; // no enabled pin is high
                default: ier = pattern;
            endcase
            write_word(gpio_pkg::REG_IER, 32'(ier));
            @(negedge seq);
            check(32'(irq), 32'((pattern & ier) != '0), $sformatf("irq with IER %h", ier));
        end
    endtask

    task automatic test_output_forming();
        logic [`GPIO_WIDTH-1:0] odr;
        logic [`GPIO_WIDTH-1:0] mode;
        logic [`GPIO_WIDTH-1:0] otype;
        logic [`GPIO_WIDTH-1:0] exp_oe;
        $display("Test 4: output forming");
        write_word(gpio_pkg::REG_FSR0, 32'd0);
        write_word(gpio_pkg::REG_FSR1, 32'd0);
        for (int k = 0; k < 4; k++) begin
            odr   = `GPIO_WIDTH'($random(seed));
            mode  = `GPIO_WIDTH'($random(seed));
            otype = `GPIO_WIDTH'($random(seed));
            write_word(gpio_pkg::REG_ODR, 32'(odr));
            write_word(gpio_pkg::REG_MODER, 32'(mode));
            write_word(gpio_pkg::REG_OTYPER, 32'(otype));
            @(negedge seq);
            for (int i = 0; i < `GPIO_WIDTH; i++) begin
                if (!mode[i]) exp_oe[i] = 1'b0;           // input pin
                else if (otype[i]) exp_oe[i] = !odr[i];   // open-drain drives low only
                else exp_oe[i] = 1'b1;
            end
            check(32'(pin_out), 32'(odr), "pin_out against ODR");
            check(32'(pin_oe), 32'(exp_oe), "pin_oe against mode and output type");
        end
    endtask

    task automatic test_function_select();
        logic [`GPIO_WIDTH-1:0] odr;
        logic [`GPIO_WIDTH-1:0] a1;
        logic [`GPIO_WIDTH-1:0] a2;
        logic [`GPIO_WIDTH-1:0] a3;
        logic [`GPIO_WIDTH-1:0] exp_out;
        logic [31:0]            fsr0;
        logic [31:0]            fsr1;
        logic [63:0]            codes;
        $display("Test 5: function select");
        write_word(gpio_pkg::REG_MODER, PIN_MASK);
        write_word(gpio_pkg::REG_OTYPER, 32'd0);
        for (int k = 0; k < 3; k++) begin
            a1   = `GPIO_WIDTH'($random(seed));
            a2   = `GPIO_WIDTH'($random(seed));
            a3   = `GPIO_WIDTH'($random(seed));
            odr  = `GPIO_WIDTH'($random(seed));
            fsr0 = $random(seed);
            fsr1 = (`GPIO_WIDTH > 16) ? $random(seed) : 32'd0;
            @(posedge seq);
            alt_out.alt1 <= a1;
            alt_out.alt2 <= a2;
            alt_out.alt3 <= a3;
            write_word(gpio_pkg::REG_ODR, 32'(odr));
            write_word(gpio_pkg::REG_FSR0, fsr0);
            write_word(gpio_pkg::REG_FSR1, fsr1);
            @(negedge seq);
            codes = {fsr1, fsr0};
            for (int i = 0; i < `GPIO_WIDTH; i++) begin
                case (gpio_pkg::func_sel_t'(codes[2*i +: 2]))
                    gpio_pkg::FUNC_ALT1: exp_out[i] = a1[i];
                    gpio_pkg::FUNC_ALT2: exp_out[i] = a2[i];
                    gpio_pkg::FUNC_ALT3: exp_out[i] = a3[i];
                    default:             exp_out[i] = odr[i];
                endcase
            end
            check(32'(pin_out), 32'(exp_out), $sformatf("pin_out for codes %h", codes));
            check(32'(pin_oe), PIN_MASK, "pin_oe with all push-pull outputs");
        end
    endtask

    task automatic test_pause();
        logic [`GPIO_WIDTH-1:0] pattern;
        logic [`GPIO_WIDTH-1:0] odr_old;
        logic [`GPIO_WIDTH-1:0] odr_new;
        logic [31:0]            got;
        logic                   err;
        $display("Test 6: pause");
        pattern = `GPIO_WIDTH'($random(seed)) | `GPIO_WIDTH'(1);
        odr_old = `GPIO_WIDTH'($random(seed));
        odr_new = ~odr_old;
        @(posedge seq);
        pin_in <= pattern;
        write_word(gpio_pkg::REG_IER, 32'(pattern));
        write_word(gpio_pkg::REG_ODR, 32'(odr_old));
        repeat (`GPIO_SYNC_STAGES + 1) @(posedge seq);
        @(negedge seq);
        check(32'(irq), 32'd1, "irq before pause");
        @(posedge seq);
        pause_req <= 1'b1;
        wait_pause_ack(1'b1);
        check(32'(pause_ack), 32'd1, "pause_ack after pause_req");
        check(32'(irq), 32'd0, "irq while paused");
        apb_write(gpio_pkg::REG_ODR, 32'(odr_new), 4'hf, err);
        check(32'(err), 32'd1, "write while paused not refused");
        apb_read(gpio_pkg::REG_ODR, got, err);
        check(32'(err), 32'd1, "read while paused not refused");
        check(got, 32'd0, "prdata while paused");
        @(negedge seq);
        check(32'(irq), 32'd0, "irq still masked while paused");
        @(posedge seq);
        pause_req <= 1'b0;
        wait_pause_ack(1'b0);
        check(32'(pause_ack), 32'd0, "pause_ack after release");
        apb_read(gpio_pkg::REG_ODR, got, err);
        check(32'(err), 32'd0, "read after release");
        check(got, 32'(odr_old), "ODR changed by write while paused");
        @(negedge seq);
        check(32'(irq), 32'd1, "irq after release");
        write_word(gpio_pkg::REG_ODR, 32'(odr_new));
        apb_read(gpio_pkg::REG_ODR, got, err);
        check(got, 32'(odr_new), "ODR write after release");
    endtask

    initial begin
        seed      = 32'h269f93aa;
        errors    = 0;
        checks    = 0;
        seq       = 1'b0;
        reset     = 1'b1;
        apb_req   = '0;
        pause_req = 1'b0;
        pin_in    = '0;
        alt_out   = '0;
        repeat (4) @(posedge seq);
        reset <= 1'b0;

        test_reset_and_strobes();
        test_error_responses();
        test_input_irq();
        test_output_forming();
        test_function_select();
        test_pause();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_TIME_NS);
        $display("Watchdog expired after %0d ns, run stopped", NUM_TESTS * TEST_TIME_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
hdl/gpio_pkg.sv
hdl/gpio_regs.sv
hdl/gpio_func_mux.sv
hdl/gpio_pad.sv
hdl/gpio_top.sv
tests/gpio_props.sv
tests/gpio_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the GPIO testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module gpio_tb -f src.f -o gpio_sim \
    && ./obj_dir/gpio_sim 2>&1 | tee sim.log \
    || echo "Build or simulation run failed"

grep -qx "PASS: all tests" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
